// File: rtl/fetch_pkg.sv
package fetch_pkg;

	localparam int xlen         = 32;
	localparam int line_bits    = 64; // two instructions per line
	localparam int mem_tag_bits = 4;  // zero means no tag

	// memory port command
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_command_e;

	// icache miss handler
	typedef enum logic [1:0] {
		miss_idle    = 2'h0,
		miss_request = 2'h1, // load on the bus until accepted
		miss_wait    = 2'h2, // waiting for the matching tag
		miss_fill    = 2'h3
	} miss_state_e;

endpackage

// File: rtl/fetch_pc_counter.sv
module fetch_pc_counter import fetch_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic [xlen-1:0] reset_pc,
	input  logic            pc_advance,
	input  logic            redirect,
	input  logic [xlen-1:0] redirect_pc,
	output logic [xlen-1:0] fetch_pc
);

	logic [xlen-1:0] pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (redirect) begin
			pc <= redirect_pc; // redirect wins over a fetch step
		end else if (pc_advance) begin
			pc <= pc + xlen'(4);
		end
	end

	assign fetch_pc = pc;

	// targets come from outside, keep them on a word boundary
	redirect_aligned: assert property (@(posedge clock) disable iff (reset)
		redirect |-> redirect_pc[1:0] == 2'b00);

endmodule

// File: rtl/miss_wait_timer.sv
module miss_wait_timer #(
	parameter int miss_timeout = 24
) (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic clear,
	output logic expired
);

	localparam int count_bits = $clog2(miss_timeout + 1);

	logic [count_bits-1:0] count;
	logic                  armed;

	assign expired = armed && (count == count_bits'(miss_timeout));

	always_ff @(posedge clock) begin
		if (reset) begin
			armed <= 1'b0;
			count <= '0;
		end else if (clear) begin
			armed <= 1'b0; // clear beats start in the same cycle
		end else if (start) begin
			armed <= 1'b1;
			count <= '0;
		end else if (expired) begin
			armed <= 1'b0; // one pulse, then idle until restarted
		end else if (armed) begin
			count <= count + 1'b1;
		end
	end

endmodule

// File: rtl/icache_miss_fsm.sv
module icache_miss_fsm import fetch_pkg::*; (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    icache_enable, // port is ours this cycle
	input  logic [xlen-1:0]         fetch_pc,
	input  logic                    hit,
	input  logic                    queue_full,
	input  logic                    redirect,
	input  logic [mem_tag_bits-1:0] mem2proc_response,
	input  logic [mem_tag_bits-1:0] mem2proc_tag,
	input  logic                    timer_expired,
	output logic                    queue_write,
	output logic                    pc_advance,
	output bus_command_e            imem_command,
	output logic [xlen-1:0]         imem_addr,
	output logic                    timer_start,
	output logic                    timer_clear,
	output logic                    fill_en,
	output logic [xlen-1:0]         fill_addr
);

	localparam int offset_bits = $clog2(line_bits / 8);

	miss_state_e             state;
	miss_state_e             state_next;
	logic [xlen-1:0]         miss_addr;   // line address of the pending miss
	logic [mem_tag_bits-1:0] pending_tag; // tag memory gave our load
	logic                    load_accepted;
	logic                    tag_match;
	logic                    start_miss;

	// a response only counts when we actually had the port
	assign load_accepted = (state == miss_request) && icache_enable &&
		(mem2proc_response != '0);
	assign tag_match  = (pending_tag != '0) && (mem2proc_tag == pending_tag);
	assign start_miss = (state == miss_idle) && !hit && !redirect;

	always_comb begin
		state_next   = state;
		queue_write  = 1'b0;
		pc_advance   = 1'b0;
		imem_command = bus_none;
		imem_addr    = '0;
		timer_start  = 1'b0;
		timer_clear  = redirect;
		fill_en      = 1'b0;
		case (state)
			miss_idle: begin
				if (!redirect && hit && !queue_full) begin
					queue_write = 1'b1; // entry shows at queue head next cycle
					pc_advance  = 1'b1;
				end else if (start_miss) begin
					state_next = miss_request;
				end
			end
			miss_request: begin
				imem_command = bus_load; // keep asking until accepted
				imem_addr    = miss_addr;
				if (load_accepted) begin
					state_next  = miss_wait;
					timer_start = 1'b1;
				end
			end
			miss_wait: begin
				if (tag_match) begin
					state_next  = miss_fill;
					timer_clear = 1'b1;
				end else if (timer_expired) begin
					state_next = miss_request; // reply lost, reissue
				end
			end
			miss_fill: begin
				fill_en    = 1'b1; // data was captured on the matching cycle
				state_next = miss_idle;
			end
			default: state_next = miss_idle;
		endcase
		if (redirect) begin
			state_next = miss_idle;
		end
	end

	assign fill_addr = miss_addr;

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= miss_idle;
			pending_tag <= '0;
		end else begin
			state <= state_next;
			if (redirect) begin
				pending_tag <= '0; // late tags of an abandoned miss never match
			end else if (load_accepted) begin
				pending_tag <= mem2proc_response;
			end else if ((state == miss_wait) && tag_match) begin
				pending_tag <= '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start_miss) begin
			miss_addr <= {fetch_pc[xlen-1:offset_bits], offset_bits'(0)};
		end
	end

	// reply data sits in the top level register for exactly this cycle
	fill_only_in_fill: assert property (@(posedge clock) disable iff (reset)
		fill_en |-> state == miss_fill && $past(tag_match));

	// a refused load is retried with the same line address
	load_held_until_accepted: assert property (@(posedge clock) disable iff (reset)
		imem_command == bus_load && !load_accepted && !redirect |=>
			imem_command == bus_load && imem_addr == $past(imem_addr));

endmodule

// File: rtl/icache_array.sv
module icache_array import fetch_pkg::*; #(
	parameter int cache_lines = 8
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [xlen-1:0]      lookup_addr,
	output logic                 hit,
	output logic [xlen-1:0]      inst,
	input  logic                 fill_en,
	input  logic [xlen-1:0]      fill_addr,
	input  logic [line_bits-1:0] fill_data
);

	localparam int offset_bits = $clog2(line_bits / 8);
	localparam int index_bits  = $clog2(cache_lines);
	localparam int tag_bits    = xlen - offset_bits - index_bits;

	logic [cache_lines-1:0] valid;
	logic [tag_bits-1:0]    tags  [cache_lines];
	logic [line_bits-1:0]   lines [cache_lines];

	logic [index_bits-1:0] lookup_index;
	logic [tag_bits-1:0]   lookup_tag;
	logic [index_bits-1:0] fill_index;
	logic [tag_bits-1:0]   fill_tag;
	logic [line_bits-1:0]  lookup_line;

	assign lookup_index = lookup_addr[offset_bits +: index_bits];
	assign lookup_tag   = lookup_addr[xlen-1 -: tag_bits];
	assign fill_index   = fill_addr[offset_bits +: index_bits];
	assign fill_tag     = fill_addr[xlen-1 -: tag_bits];

	assign lookup_line = lines[lookup_index];
	assign hit         = valid[lookup_index] && (tags[lookup_index] == lookup_tag);
	// bit 2 picks the word inside the line
	assign inst = lookup_addr[2] ? lookup_line[line_bits-1 -: xlen] : lookup_line[xlen-1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (fill_en) begin
			valid[fill_index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_en) begin
			tags[fill_index]  <= fill_tag;
			lines[fill_index] <= fill_data;
		end
	end

	// the miss handler always hands over a whole line address
	fill_line_aligned: assert property (@(posedge clock) disable iff (reset)
		fill_en |-> fill_addr[offset_bits-1:0] == '0);

endmodule

// File: rtl/inst_queue.sv
module inst_queue import fetch_pkg::*; #(
	parameter int queue_depth = 4
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            write,
	input  logic [xlen-1:0] write_pc,
	input  logic [xlen-1:0] write_inst,
	input  logic            flush,
	input  logic            take,
	output logic            full,
	output logic            out_valid,
	output logic [xlen-1:0] out_pc,
	output logic [xlen-1:0] out_inst
);

	localparam int ptr_bits   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int count_bits = $clog2(queue_depth + 1);

	logic [xlen-1:0]       pc_mem   [queue_depth];
	logic [xlen-1:0]       inst_mem [queue_depth];
	logic [ptr_bits-1:0]   head;
	logic [ptr_bits-1:0]   tail;
	logic [count_bits-1:0] count;
	logic                  do_write;
	logic                  do_take;

	assign full      = (count == count_bits'(queue_depth));
	assign out_valid = (count != '0);
	assign out_pc    = pc_mem[head];
	assign out_inst  = inst_mem[head];

	assign do_write = write && !full;
	assign do_take  = take && out_valid; // pop in the cycle the head is seen

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head  <= '0; // flush drops a same-cycle write as well
			tail  <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				tail <= (tail == ptr_bits'(queue_depth - 1)) ? '0 : tail + 1'b1;
			end
			if (do_take) begin
				head <= (head == ptr_bits'(queue_depth - 1)) ? '0 : head + 1'b1;
			end
			count <= count + count_bits'(do_write) - count_bits'(do_take);
		end
	end

	always_ff @(posedge clock) begin
		if (do_write) begin
			pc_mem[tail]   <= write_pc;
			inst_mem[tail] <= write_inst;
		end
	end

	no_write_when_full: assert property (@(posedge clock) disable iff (reset || flush)
		write |-> !full);

	no_take_when_empty: assert property (@(posedge clock) disable iff (reset || flush)
		take |-> out_valid);

endmodule

// File: rtl/fetch_top.sv
module fetch_top import fetch_pkg::*; #(
	parameter int cache_lines  = 8,
	parameter int queue_depth  = 4,
	parameter int miss_timeout = 24
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [xlen-1:0]         reset_pc,
	input  logic                    redirect,
	input  logic [xlen-1:0]         redirect_pc,
	input  logic                    out_take,
	output logic                    out_valid,
	output logic [xlen-1:0]         out_pc,
	output logic [xlen-1:0]         out_inst,
	input  bus_command_e            dcache_command,
	input  logic [xlen-1:0]         dcache_addr,
	input  logic [line_bits-1:0]    dcache_data,
	input  logic [mem_tag_bits-1:0] mem2proc_response,
	input  logic [line_bits-1:0]    mem2proc_data,
	input  logic [mem_tag_bits-1:0] mem2proc_tag,
	output bus_command_e            mem_command,
	output logic [xlen-1:0]         mem_addr,
	output logic [line_bits-1:0]    mem_data
);

	logic [xlen-1:0]      fetch_pc;
	logic                 pc_advance;
	logic                 hit;
	logic [xlen-1:0]      inst;
	logic                 queue_full;
	logic                 queue_write;
	bus_command_e         imem_command;
	logic [xlen-1:0]      imem_addr;
	logic                 icache_enable;
	logic                 timer_start;
	logic                 timer_clear;
	logic                 timer_expired;
	logic                 fill_en;
	logic [xlen-1:0]      fill_addr;
	logic [line_bits-1:0] fill_data_q; // reply data from last cycle

	// data side owns the port whenever it asks for it
	assign icache_enable = (dcache_command == bus_none);

	always_comb begin
		mem_command = icache_enable ? imem_command : dcache_command;
		mem_addr    = icache_enable ? imem_addr : dcache_addr;
		mem_data    = dcache_data; // only stores carry data
	end

	// fill happens in miss_fill, one cycle after the tag matched
	always_ff @(posedge clock) begin
		fill_data_q <= mem2proc_data;
	end

	fetch_pc_counter pc_counter_inst (
		.clock       (clock),
		.reset       (reset),
		.reset_pc    (reset_pc),
		.pc_advance  (pc_advance),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_pc    (fetch_pc)
	);

	icache_array #(.cache_lines(cache_lines)) icache_array_inst (
		.clock       (clock),
		.reset       (reset),
		.lookup_addr (fetch_pc),
		.hit         (hit),
		.inst        (inst),
		.fill_en     (fill_en),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data_q)
	);

	icache_miss_fsm miss_fsm_inst (
		.clock             (clock),
		.reset             (reset),
		.icache_enable     (icache_enable),
		.fetch_pc          (fetch_pc),
		.hit               (hit),
		.queue_full        (queue_full),
		.redirect          (redirect),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.timer_expired     (timer_expired),
		.queue_write       (queue_write),
		.pc_advance        (pc_advance),
		.imem_command      (imem_command),
		.imem_addr         (imem_addr),
		.timer_start       (timer_start),
		.timer_clear       (timer_clear),
		.fill_en           (fill_en),
		.fill_addr         (fill_addr)
	);

	miss_wait_timer #(.miss_timeout(miss_timeout)) wait_timer_inst (
		.clock   (clock),
		.reset   (reset),
		.start   (timer_start),
		.clear   (timer_clear),
		.expired (timer_expired)
	);

	inst_queue #(.queue_depth(queue_depth)) inst_queue_inst (
		.clock      (clock),
		.reset      (reset),
		.write      (queue_write),
		.write_pc   (fetch_pc),
		.write_inst (inst),
		.flush      (redirect),
		.take       (out_take),
		.full       (queue_full),
		.out_valid  (out_valid),
		.out_pc     (out_pc),
		.out_inst   (out_inst)
	);

endmodule

// File: dv/tb_mem_model.sv
module tb_mem_model import fetch_pkg::*; #(
	parameter logic [xlen-1:0] image_key = 32'hc0de0000,
	parameter logic [xlen-1:0] drop_addr = 32'h0000_1050
) (
	input  logic                    clock,
	input  logic                    reset,
	input  bus_command_e            mem_command,
	input  logic [xlen-1:0]         mem_addr,
	output logic [mem_tag_bits-1:0] mem2proc_response,
	output logic [line_bits-1:0]    mem2proc_data,
	output logic [mem_tag_bits-1:0] mem2proc_tag,
	output logic                    dropped,
	output logic                    reissued
);

	logic                    refuse; // random busy cycle, load gets response zero
	logic [mem_tag_bits-1:0] next_tag;
	logic                    acc_valid;
	logic [mem_tag_bits-1:0] acc_tag;
	logic [xlen-1:0]         acc_addr;
	logic                    busy    [16];
	logic [xlen-1:0]         addr_of [16];
	int                      wait_of [16];

	assign mem2proc_response = (mem_command == bus_load && !refuse) ? next_tag : '0;

	// accepted loads are sampled where the bus is stable
	always @(posedge clock) begin
		acc_valid <= !reset && (mem2proc_response != '0);
		acc_tag   <= mem2proc_response;
		acc_addr  <= mem_addr;
	end

	always @(negedge clock) begin
		logic [xlen-1:0] base;
		if (reset) begin
			next_tag      = mem_tag_bits'(1);
			refuse        = 1'b0;
			mem2proc_tag  = '0;
			mem2proc_data = '0;
			dropped       = 1'b0;
			reissued      = 1'b0;
			for (int t = 0; t < 16; t++) begin
				busy[t] = 1'b0;
			end
		end else begin
			mem2proc_tag  = '0;
			mem2proc_data = '0;
			for (int t = 1; t < 16; t++) begin
				if (busy[t]) begin
					wait_of[t] = wait_of[t] - 1;
					if (wait_of[t] <= 0 && mem2proc_tag == '0) begin
						base          = {addr_of[t][xlen-1:3], 3'b000};
						mem2proc_tag  = mem_tag_bits'(t);
						mem2proc_data = {(base + 32'd4) ^ image_key, base ^ image_key};
						busy[t]       = 1'b0;
					end
				end
			end
			if (acc_valid) begin
				next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
				if (acc_addr == drop_addr && !dropped) begin
					dropped = 1'b1; // swallowed, data never comes
				end else begin
					if (acc_addr == drop_addr) begin
						reissued = 1'b1;
					end
					busy[acc_tag]    = 1'b1;
					addr_of[acc_tag] = acc_addr;
					wait_of[acc_tag] = 2 + int'($urandom % 8);
				end
			end
			refuse = ($urandom % 5) == 0;
		end
	end

endmodule

// File: dv/tb_fetch_top.sv
module tb_fetch_top import fetch_pkg::*; ();

	localparam logic [31:0]     seed           = 32'h7273;
	localparam logic [xlen-1:0] reset_pc_value = 32'h0000_1000;
	localparam logic [xlen-1:0] image_key      = 32'hc0de0000; // inst at a is a ^ key
	localparam logic [xlen-1:0] drop_line      = 32'h0000_1050;
	localparam int              wait_limit     = 400;

	logic                    clock;
	logic                    reset;
	logic [xlen-1:0]         reset_pc;
	logic                    redirect;
	logic [xlen-1:0]         redirect_pc;
	logic                    out_take;
	logic                    out_valid;
	logic [xlen-1:0]         out_pc;
	logic [xlen-1:0]         out_inst;
	bus_command_e            dcache_command;
	logic [xlen-1:0]         dcache_addr;
	logic [line_bits-1:0]    dcache_data;
	logic [mem_tag_bits-1:0] mem2proc_response;
	logic [line_bits-1:0]    mem2proc_data;
	logic [mem_tag_bits-1:0] mem2proc_tag;
	bus_command_e            mem_command;
	logic [xlen-1:0]         mem_addr;
	logic [line_bits-1:0]    mem_data;
	logic                    dropped;
	logic                    reissued;

	logic [xlen-1:0] expect_pc; // next pc the consumer should see
	int              delivered;
	int              errors;
	int              tests_run;
	logic            watch_on;
	logic [xlen-5:0] watch_block; // 16-byte block that must not be loaded again

	fetch_top fetch_top_inst (.*);

	tb_mem_model #(.image_key(image_key), .drop_addr(drop_line)) mem_model_inst (.*);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		if (reset) begin
			expect_pc <= reset_pc_value;
			delivered <= 0;
		end else if (redirect) begin
			expect_pc <= redirect_pc;
		end else if (out_valid && out_take) begin
			expect_pc <= expect_pc + 32'd4;
			delivered <= delivered + 1;
		end
	end

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		errors++;
		$display("FAIL %s got %h expected %h", name, got, want);
	endtask

	quiet_valid: assert property (@(posedge clock) $fell(reset) |-> !out_valid)
		else report_mismatch("out_valid", 64'($sampled(out_valid)), 64'h0);
	quiet_command: assert property (@(posedge clock) $fell(reset) |-> mem_command == bus_none)
		else report_mismatch("mem_command", 64'($sampled(mem_command)), 64'(bus_none));
	pc_in_order: assert property (@(posedge clock) disable iff (reset)
		out_valid && out_take |-> out_pc == expect_pc)
		else report_mismatch("out_pc", 64'($sampled(out_pc)), 64'($sampled(expect_pc)));
	inst_image: assert property (@(posedge clock) disable iff (reset)
		out_valid && out_take |-> out_inst == (expect_pc ^ image_key))
		else report_mismatch("out_inst", 64'($sampled(out_inst)),
			64'($sampled(expect_pc) ^ image_key));
	dcache_command_wins: assert property (@(posedge clock) disable iff (reset)
		dcache_command != bus_none |-> mem_command == dcache_command)
		else report_mismatch("mem_command", 64'($sampled(mem_command)),
			64'($sampled(dcache_command)));
	dcache_addr_wins: assert property (@(posedge clock) disable iff (reset)
		dcache_command != bus_none |-> mem_addr == dcache_addr)
		else report_mismatch("mem_addr", 64'($sampled(mem_addr)), 64'($sampled(dcache_addr)));
	data_pass: assert property (@(posedge clock) disable iff (reset) mem_data == dcache_data)
		else report_mismatch("mem_data", $sampled(mem_data), $sampled(dcache_data));
	flush_empties: assert property (@(posedge clock) disable iff (reset)
		redirect |=> !out_valid)
		else report_mismatch("out_valid", 64'($sampled(out_valid)), 64'h0);
	no_refetch: assert property (@(posedge clock) disable iff (reset)
		watch_on && mem_command == bus_load |-> mem_addr[xlen-1:4] != watch_block)
		else begin
			errors++;
			$display("FAIL mem_addr %h loads a line that is already cached",
				$sampled(mem_addr));
		end

	// take only what is there, about three cycles in four
	task automatic drive_cycle(input logic take_ok);
		@(negedge clock);
		out_take = take_ok && out_valid && (($urandom % 4) != 0);
	endtask

	task automatic stall(input int cycles);
		repeat (cycles) drive_cycle(1'b0);
	endtask

	task automatic collect(input int count, input string what);
		int target;
		int cycles;
		target = delivered + count;
		cycles = 0;
		while (delivered < target && cycles < wait_limit) begin
			drive_cycle(1'b1);
			cycles++;
		end
		out_take = 1'b0;
		if (delivered < target) begin
			errors++;
			$display("timeout: only %0d of %0d entries arrived for %s",
				count - (target - delivered), count, what);
		end
	endtask

	task automatic drive_dcache(input int cycles);
		repeat (cycles) begin
			drive_cycle(1'b1);
			dcache_command = bus_command_e'($urandom % 3);
			dcache_addr    = 32'h0000_8000 | ($urandom & 32'h0000_0ff8);
			dcache_data    = {$urandom, $urandom};
		end
		drive_cycle(1'b1);
		dcache_command = bus_none;
	endtask

	task automatic send_redirect(input logic [xlen-1:0] target);
		@(negedge clock);
		out_take    = 1'b0;
		redirect    = 1'b1;
		redirect_pc = target;
		@(negedge clock);
		redirect = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	initial begin
		int errors_before;
		void'($urandom(seed));
		clock          = 1'b0;
		reset          = 1'b1;
		reset_pc       = reset_pc_value;
		redirect       = 1'b0;
		redirect_pc    = '0;
		out_take       = 1'b0;
		dcache_command = bus_none;
		dcache_addr    = '0;
		dcache_data    = '0;
		errors         = 0;
		tests_run      = 0;
		watch_on       = 1'b0;
		watch_block    = '0;
		repeat (10) @(negedge clock);
		reset = 1'b0;

		errors_before = errors;
		stall(2);
		finish_test("reset state", errors_before);

		errors_before = errors;
		collect(6, "sequential fetch");
		stall(8); // queue fills, pc must hold
		collect(6, "fetch after back-pressure");
		stall(5);
		collect(4, "fetch after second stall");
		finish_test("sequential fetch", errors_before);

		errors_before = errors;
		drive_dcache(12);
		collect(4, "fetch after dcache traffic");
		finish_test("dcache priority", errors_before);

		errors_before = errors;
		collect(8, "fetch across dropped line");
		assert (dropped) else begin
			errors++;
			$display("memory model never saw the line chosen for dropping");
		end
		assert (reissued) else begin
			errors++;
			$display("dropped line was never requested again");
		end
		finish_test("dropped reply reissue", errors_before);

		errors_before = errors;
		send_redirect(32'h0000_2000);
		collect(6, "fetch after redirect");
		finish_test("redirect", errors_before);

		errors_before = errors;
		stall(6);
		watch_block = 28'h0000_200;
		watch_on    = 1'b1;
		send_redirect(32'h0000_2000);
		collect(4, "refetch from cached lines");
		stall(1);
		watch_on = 1'b0;
		finish_test("redirect to cached lines", errors_before);

		$display("tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: sources.f
rtl/fetch_pkg.sv
rtl/fetch_pc_counter.sv
rtl/miss_wait_timer.sv
rtl/icache_miss_fsm.sv
rtl/icache_array.sv
rtl/inst_queue.sv
rtl/fetch_top.sv
dv/tb_mem_model.sv
dv/tb_fetch_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fetch_top -f sources.f
./obj_dir/Vtb_fetch_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
